/* bank_request_queue.sv */
module bank_request_queue (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             req_valid,
    input  logic [oc_pkg::slot_w-1:0]                        req_slot,
    input  logic [oc_pkg::warp_w-1:0]                        req_warp,
    input  logic [oc_pkg::reg_w-1:0]                         req_src1,
    input  logic                                             req_src1_valid,
    input  logic [oc_pkg::reg_w-1:0]                         req_src2,
    input  logic                                             req_src2_valid,
    input  logic                                             wb_valid,
    input  logic [oc_pkg::warp_w-1:0]                        wb_warp,
    input  logic [oc_pkg::reg_w-1:0]                         wb_reg,
    input  logic [oc_pkg::data_w-1:0]                        wb_data,
    output logic [oc_pkg::num_banks-1:0]                     rd_en,
    output logic [oc_pkg::num_banks-1:0][oc_pkg::row_w-1:0]  rd_row,
    output logic [oc_pkg::num_banks-1:0][oc_pkg::tag_w-1:0]  rd_tag,
    output logic [oc_pkg::num_banks-1:0]                     wr_en,
    output logic [oc_pkg::num_banks-1:0][oc_pkg::row_w-1:0]  wr_row,
    output logic [oc_pkg::num_banks-1:0][oc_pkg::data_w-1:0] wr_data
);
    import oc_pkg::*;

    function automatic logic [bank_w-1:0] bank_of(input logic [warp_w-1:0] w,
                                                  input logic [reg_w-1:0] r);
        return bank_w'(w + r);
    endfunction

    function automatic logic [row_w-1:0] row_of(input logic [warp_w-1:0] w,
                                                input logic [reg_w-1:0] r);
        return row_w'(w) * row_w'(regs_per_warp / num_banks) + row_w'(r / num_banks);
    endfunction

    logic [bank_w-1:0]        bank1, bank2, wb_bank;
    logic [row_w-1:0]         row1, row2, wb_row;
    logic [row_w+tag_w-1:0]   ent1, ent2;

    assign bank1   = bank_of(req_warp, req_src1);
    assign bank2   = bank_of(req_warp, req_src2);
    assign row1    = row_of(req_warp, req_src1);
    assign row2    = row_of(req_warp, req_src2);
    assign wb_bank = bank_of(wb_warp, wb_reg);
    assign wb_row  = row_of(wb_warp, wb_reg);
    assign ent1    = {row1, req_slot, 1'b0};
    assign ent2    = {row2, req_slot, 1'b1};

    for (genvar b = 0; b < num_banks; b++) begin : g_bank
        logic                   push1, push2, pop;
        logic [row_w+tag_w-1:0] q_mem [queue_depth];
        logic [qptr_w-1:0]      wptr, rptr;
        logic [qptr_w:0]        count;

        assign push1      = req_valid && req_src1_valid && bank1 == bank_w'(b);
        assign push2      = req_valid && req_src2_valid && bank2 == bank_w'(b);
        assign wr_en[b]   = wb_valid && wb_bank == bank_w'(b);
        assign wr_row[b]  = wb_row;
        assign wr_data[b] = wb_data;
        assign pop        = count != '0 && !wr_en[b]; // write-back owns the port
        assign rd_en[b]   = pop;
        assign {rd_row[b], rd_tag[b]} = q_mem[rptr];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wptr  <= '0;
                rptr  <= '0;
                count <= '0;
            end else begin
                wptr  <= wptr + qptr_w'(push1) + qptr_w'(push2);
                rptr  <= rptr + qptr_w'(pop);
                count <= count + (qptr_w + 1)'(push1) + (qptr_w + 1)'(push2)
                         - (qptr_w + 1)'(pop);
            end
        end

        always_ff @(posedge clk) begin
            if (push1)
                q_mem[wptr] <= ent1;
            if (push2)
                q_mem[push1 ? wptr + 1'b1 : wptr] <= ent2; // both sources in one bank
        end

        a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
            (push1 || push2) |-> count + push1 + push2 <= queue_depth)
            else $error("bank %0d request queue overflow", b);
    end

endmodule

/* collector_slots.sv */
module collector_slots (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic                                             issue_valid,
    input  logic [oc_pkg::warp_w-1:0]                        warp_id,
    input  logic [oc_pkg::reg_w-1:0]                         src1,
    input  logic                                             src1_valid,
    input  logic [oc_pkg::reg_w-1:0]                         src2,
    input  logic                                             src2_valid,
    input  logic [oc_pkg::reg_w-1:0]                         dst,
    input  oc_pkg::alu_op_e                                  alu_op,
    input  logic                                             mem_read,
    input  logic                                             mem_write,
    input  logic [oc_pkg::imme_w-1:0]                        imme,
    input  logic                                             imme_valid,
    input  logic [oc_pkg::num_banks-1:0]                     rd_data_valid,
    input  logic [oc_pkg::num_banks-1:0][oc_pkg::data_w-1:0] rd_data,
    input  logic [oc_pkg::num_banks-1:0][oc_pkg::tag_w-1:0]  rd_data_tag,
    input  logic [oc_pkg::num_slots-1:0]                     slot_release,
    output logic                                             oc_full,
    output logic                                             req_valid,
    output logic [oc_pkg::slot_w-1:0]                        req_slot,
    output logic [oc_pkg::warp_w-1:0]                        req_warp,
    output logic [oc_pkg::reg_w-1:0]                         req_src1,
    output logic                                             req_src1_valid,
    output logic [oc_pkg::reg_w-1:0]                         req_src2,
    output logic                                             req_src2_valid,
    output logic [oc_pkg::num_slots-1:0]                     slot_ready,
    output logic [oc_pkg::num_slots-1:0]                     slot_is_mem,
    output logic [oc_pkg::num_slots-1:0][oc_pkg::data_w-1:0] slot_src1,
    output logic [oc_pkg::num_slots-1:0][oc_pkg::data_w-1:0] slot_src2,
    output logic [oc_pkg::num_slots-1:0][oc_pkg::warp_w-1:0] slot_warp,
    output logic [oc_pkg::num_slots-1:0][oc_pkg::reg_w-1:0]  slot_dst,
    output oc_pkg::alu_op_e [oc_pkg::num_slots-1:0]          slot_alu_op,
    output logic [oc_pkg::num_slots-1:0]                     slot_mem_read,
    output logic [oc_pkg::num_slots-1:0]                     slot_mem_write,
    output logic [oc_pkg::num_slots-1:0][oc_pkg::imme_w-1:0] slot_imme,
    output logic [oc_pkg::num_slots-1:0]                     slot_imme_valid
);
    import oc_pkg::*;

    slot_state_e       state [num_slots];
    logic [1:0]        present [num_slots];
    logic [1:0]        present_nxt [num_slots];
    logic [slot_w-1:0] alloc_slot;
    logic              take;

    always_comb begin
        oc_full    = 1'b1;
        alloc_slot = '0;
        for (int s = num_slots - 1; s >= 0; s--) begin
            if (state[s] == st_free) begin
                oc_full    = 1'b0;
                alloc_slot = slot_w'(s); // lowest free wins
            end
        end
    end

    assign take           = issue_valid && !oc_full;
    assign req_valid      = take;
    assign req_slot       = alloc_slot;
    assign req_warp       = warp_id;
    assign req_src1       = src1;
    assign req_src1_valid = src1_valid;
    assign req_src2       = src2;
    assign req_src2_valid = src2_valid;

    always_comb begin
        for (int s = 0; s < num_slots; s++) begin
            present_nxt[s] = present[s];
            for (int b = 0; b < num_banks; b++) begin
                if (rd_data_valid[b] && rd_data_tag[b][tag_w-1:1] == slot_w'(s))
                    present_nxt[s][rd_data_tag[b][0]] = 1'b1;
            end
            slot_ready[s]  = state[s] == st_ready;
            slot_is_mem[s] = slot_mem_read[s] || slot_mem_write[s];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < num_slots; s++) begin
                state[s]   <= st_free;
                present[s] <= '0;
            end
        end else begin
            for (int s = 0; s < num_slots; s++) begin
                case (state[s])
                    st_free: begin
                        if (take && alloc_slot == slot_w'(s)) begin
                            state[s]   <= st_collecting;
                            present[s] <= {!src2_valid, !src1_valid}; // unused ones done
                        end
                    end
                    st_collecting: begin
                        present[s] <= present_nxt[s];
                        if (&present_nxt[s])
                            state[s] <= st_ready;
                    end
                    default: begin
                        if (slot_release[s])
                            state[s] <= st_free;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < num_slots; s++) begin
            if (take && alloc_slot == slot_w'(s)) begin
                slot_src1[s]       <= '0;
                slot_src2[s]       <= '0;
                slot_warp[s]       <= warp_id;
                slot_dst[s]        <= dst;
                slot_alu_op[s]     <= alu_op;
                slot_mem_read[s]   <= mem_read;
                slot_mem_write[s]  <= mem_write;
                slot_imme[s]       <= imme;
                slot_imme_valid[s] <= imme_valid;
            end
        end
        for (int b = 0; b < num_banks; b++) begin
            if (rd_data_valid[b]) begin
                if (rd_data_tag[b][0])
                    slot_src2[rd_data_tag[b][tag_w-1:1]] <= rd_data[b];
                else
                    slot_src1[rd_data_tag[b][tag_w-1:1]] <= rd_data[b];
            end
        end
    end

    a_issue_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !oc_full)
        else $error("issue while collector slots full");

    for (genvar b = 0; b < num_banks; b++) begin : g_chk
        a_data_to_live_slot: assert property (@(posedge clk) disable iff (!rst_n)
            rd_data_valid[b] |-> state[rd_data_tag[b][tag_w-1:1]] != st_free)
            else $error("bank %0d returned data for a free slot", b);
    end

endmodule

/* dispatch_scheduler.sv */
module dispatch_scheduler (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [oc_pkg::num_slots-1:0]                     slot_ready,
    input  logic [oc_pkg::num_slots-1:0]                     slot_is_mem,
    input  logic [oc_pkg::num_slots-1:0][oc_pkg::data_w-1:0] slot_src1,
    input  logic [oc_pkg::num_slots-1:0][oc_pkg::data_w-1:0] slot_src2,
    input  logic [oc_pkg::num_slots-1:0][oc_pkg::warp_w-1:0] slot_warp,
    input  logic [oc_pkg::num_slots-1:0][oc_pkg::reg_w-1:0]  slot_dst,
    input  oc_pkg::alu_op_e [oc_pkg::num_slots-1:0]          slot_alu_op,
    input  logic [oc_pkg::num_slots-1:0]                     slot_mem_read,
    input  logic [oc_pkg::num_slots-1:0]                     slot_mem_write,
    input  logic [oc_pkg::num_slots-1:0][oc_pkg::imme_w-1:0] slot_imme,
    input  logic [oc_pkg::num_slots-1:0]                     slot_imme_valid,
    output logic [oc_pkg::num_slots-1:0]                     slot_release,
    output logic                                             alu_valid,
    output logic [oc_pkg::data_w-1:0]                        alu_src1,
    output logic [oc_pkg::data_w-1:0]                        alu_src2,
    output logic [oc_pkg::warp_w-1:0]                        alu_warp,
    output logic [oc_pkg::reg_w-1:0]                         alu_dst,
    output oc_pkg::alu_op_e                                  alu_op_out,
    output logic [oc_pkg::imme_w-1:0]                        alu_imme,
    output logic                                             alu_imme_valid,
    output logic                                             mem_valid,
    output logic [oc_pkg::data_w-1:0]                        mem_src1,
    output logic [oc_pkg::data_w-1:0]                        mem_src2,
    output logic [oc_pkg::warp_w-1:0]                        mem_warp,
    output logic [oc_pkg::reg_w-1:0]                         mem_dst,
    output logic                                             mem_read_out,
    output logic                                             mem_write_out,
    output logic [oc_pkg::imme_w-1:0]                        mem_imme,
    output logic                                             mem_imme_valid
);
    import oc_pkg::*;

    // returns {found, index}, searching upward from ptr
    function automatic logic [slot_w:0] rr_pick(input logic [num_slots-1:0] req,
                                                input logic [slot_w-1:0] ptr);
        logic [slot_w:0]   pick;
        logic [slot_w-1:0] idx;
        pick = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            idx = ptr + slot_w'(i);
            if (req[idx])
                pick = {1'b1, idx};
        end
        return pick;
    endfunction

    logic [slot_w:0]   alu_pick, mem_pick;
    logic [slot_w-1:0] alu_ptr, mem_ptr;
    logic [slot_w-1:0] alu_sel, mem_sel;

    assign alu_pick = rr_pick(slot_ready & ~slot_is_mem, alu_ptr);
    assign mem_pick = rr_pick(slot_ready & slot_is_mem, mem_ptr);
    assign alu_sel  = alu_pick[slot_w-1:0];
    assign mem_sel  = mem_pick[slot_w-1:0];

    always_comb begin
        slot_release = '0;
        if (alu_pick[slot_w])
            slot_release[alu_sel] = 1'b1;
        if (mem_pick[slot_w])
            slot_release[mem_sel] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
            mem_valid <= 1'b0;
            alu_ptr   <= '0;
            mem_ptr   <= '0;
        end else begin
            alu_valid <= alu_pick[slot_w];
            mem_valid <= mem_pick[slot_w];
            if (alu_pick[slot_w])
                alu_ptr <= alu_sel + 1'b1; // start after last grant
            if (mem_pick[slot_w])
                mem_ptr <= mem_sel + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_pick[slot_w]) begin
            alu_src1       <= slot_src1[alu_sel];
            alu_src2       <= slot_src2[alu_sel];
            alu_warp       <= slot_warp[alu_sel];
            alu_dst        <= slot_dst[alu_sel];
            alu_op_out     <= slot_alu_op[alu_sel];
            alu_imme       <= slot_imme[alu_sel];
            alu_imme_valid <= slot_imme_valid[alu_sel];
        end
        if (mem_pick[slot_w]) begin
            mem_src1       <= slot_src1[mem_sel];
            mem_src2       <= slot_src2[mem_sel];
            mem_warp       <= slot_warp[mem_sel];
            mem_dst        <= slot_dst[mem_sel];
            mem_read_out   <= slot_mem_read[mem_sel];
            mem_write_out  <= slot_mem_write[mem_sel];
            mem_imme       <= slot_imme[mem_sel];
            mem_imme_valid <= slot_imme_valid[mem_sel];
        end
    end

endmodule

/* oc_pkg.sv */
package oc_pkg;

    localparam int data_w        = 32;
    localparam int num_warps     = 8;
    localparam int warp_w        = $clog2(num_warps);
    localparam int regs_per_warp = 8;
    localparam int reg_w         = $clog2(regs_per_warp);
    localparam int num_banks     = 4;
    localparam int bank_w        = $clog2(num_banks);
    localparam int bank_rows     = num_warps * regs_per_warp / num_banks;
    localparam int row_w         = $clog2(bank_rows);
    localparam int num_slots     = 4;
    localparam int slot_w        = $clog2(num_slots);
    localparam int tag_w         = slot_w + 1;     // slot index, operand bit at lsb
    localparam int queue_depth   = 2 * num_slots;  // every operand of every slot fits
    localparam int qptr_w        = $clog2(queue_depth);
    localparam int imme_w        = 16;

    typedef enum logic [3:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_shl,
        op_shr,
        op_slt,
        op_sltu,
        op_sra,
        op_mul,
        op_min,
        op_max,
        op_mov,
        op_not,
        op_nop
    } alu_op_e;

    typedef enum logic [1:0] {
        st_free,
        st_collecting,
        st_ready
    } slot_state_e;

endpackage

/* register_bank_array.sv */
module register_bank_array (
    input  logic                                             clk,
    input  logic [oc_pkg::num_banks-1:0]                     rd_en,
    input  logic [oc_pkg::num_banks-1:0][oc_pkg::row_w-1:0]  rd_row,
    input  logic [oc_pkg::num_banks-1:0][oc_pkg::tag_w-1:0]  rd_tag,
    input  logic [oc_pkg::num_banks-1:0]                     wr_en,
    input  logic [oc_pkg::num_banks-1:0][oc_pkg::row_w-1:0]  wr_row,
    input  logic [oc_pkg::num_banks-1:0][oc_pkg::data_w-1:0] wr_data,
    output logic [oc_pkg::num_banks-1:0]                     rd_data_valid,
    output logic [oc_pkg::num_banks-1:0][oc_pkg::data_w-1:0] rd_data,
    output logic [oc_pkg::num_banks-1:0][oc_pkg::tag_w-1:0]  rd_data_tag
);
    import oc_pkg::*;

    logic [data_w-1:0] mem [num_banks][bank_rows];

    always_ff @(posedge clk) begin
        for (int b = 0; b < num_banks; b++) begin
            if (wr_en[b])
                mem[b][wr_row[b]] <= wr_data[b];
            rd_data_valid[b] <= rd_en[b];
            if (rd_en[b]) begin
                rd_data[b]     <= mem[b][rd_row[b]];
                rd_data_tag[b] <= rd_tag[b]; // tag rides with the data
            end
        end
    end

endmodule

/* rfoc_top.f */
oc_pkg.sv
register_bank_array.sv
bank_request_queue.sv
collector_slots.sv
dispatch_scheduler.sv
rfoc_top.sv
tb_rfoc_top.sv

/* rfoc_top.sv */
module rfoc_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      issue_valid,
    input  logic [oc_pkg::warp_w-1:0] warp_id,
    input  logic [oc_pkg::reg_w-1:0]  src1,
    input  logic                      src1_valid,
    input  logic [oc_pkg::reg_w-1:0]  src2,
    input  logic                      src2_valid,
    input  logic [oc_pkg::reg_w-1:0]  dst,
    input  oc_pkg::alu_op_e           alu_op,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic [oc_pkg::imme_w-1:0] imme,
    input  logic                      imme_valid,
    input  logic                      wb_valid,
    input  logic [oc_pkg::warp_w-1:0] wb_warp,
    input  logic [oc_pkg::reg_w-1:0]  wb_reg,
    input  logic [oc_pkg::data_w-1:0] wb_data,
    output logic                      oc_full,
    output logic                      alu_valid,
    output logic [oc_pkg::data_w-1:0] alu_src1,
    output logic [oc_pkg::data_w-1:0] alu_src2,
    output logic [oc_pkg::warp_w-1:0] alu_warp,
    output logic [oc_pkg::reg_w-1:0]  alu_dst,
    output oc_pkg::alu_op_e           alu_op_out,
    output logic [oc_pkg::imme_w-1:0] alu_imme,
    output logic                      alu_imme_valid,
    output logic                      mem_valid,
    output logic [oc_pkg::data_w-1:0] mem_src1,
    output logic [oc_pkg::data_w-1:0] mem_src2,
    output logic [oc_pkg::warp_w-1:0] mem_warp,
    output logic [oc_pkg::reg_w-1:0]  mem_dst,
    output logic                      mem_read_out,
    output logic                      mem_write_out,
    output logic [oc_pkg::imme_w-1:0] mem_imme,
    output logic                      mem_imme_valid
);
    import oc_pkg::*;

    // slot allocation to bank queues
    logic                 req_valid, req_src1_valid, req_src2_valid;
    logic [slot_w-1:0]    req_slot;
    logic [warp_w-1:0]    req_warp;
    logic [reg_w-1:0]     req_src1, req_src2;

    // bank ports
    logic [num_banks-1:0]             rd_en, wr_en, rd_data_valid;
    logic [num_banks-1:0][row_w-1:0]  rd_row, wr_row;
    logic [num_banks-1:0][tag_w-1:0]  rd_tag, rd_data_tag;
    logic [num_banks-1:0][data_w-1:0] wr_data, rd_data;

    // slot contents to scheduler
    logic [num_slots-1:0]             slot_ready, slot_is_mem, slot_release;
    logic [num_slots-1:0]             slot_mem_read, slot_mem_write, slot_imme_valid;
    logic [num_slots-1:0][data_w-1:0] slot_src1, slot_src2;
    logic [num_slots-1:0][warp_w-1:0] slot_warp;
    logic [num_slots-1:0][reg_w-1:0]  slot_dst;
    alu_op_e [num_slots-1:0]          slot_alu_op;
    logic [num_slots-1:0][imme_w-1:0] slot_imme;

    collector_slots     collector_slots_inst     (.*);
    bank_request_queue  bank_request_queue_inst  (.*);
    register_bank_array register_bank_array_inst (.*);
    dispatch_scheduler  dispatch_scheduler_inst  (.*);

endmodule

/* run.sh */
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_rfoc_top \
    -f rfoc_top.f -o sim_rfoc \
    && ./obj_dir/sim_rfoc | tee /dev/stderr | grep -q "^Test OK$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_rfoc_top.sv */
module tb_rfoc_top;
    timeunit 1ns;
    timeprecision 1ps;
    import oc_pkg::*;

    localparam int clk_period   = 20;
    localparam int reset_cycles = 16;
    localparam int rand_instr   = 40;
    localparam int num_instr    = 7 + rand_instr;  // directed ones plus the random stream

    typedef struct packed {
        logic              is_mem;
        logic [warp_w-1:0] warp;
        logic [reg_w-1:0]  dst;
        logic [data_w-1:0] src1;
        logic [data_w-1:0] src2;
        logic [3:0]        op;
        logic              mrd;
        logic              mwr;
        logic [imme_w-1:0] imme;
        logic              imme_valid;
    } op_rec_t;

    logic              clk, rst_n;
    logic              issue_valid, src1_valid, src2_valid, mem_read, mem_write, imme_valid;
    logic [warp_w-1:0] warp_id, wb_warp, alu_warp, mem_warp;
    logic [reg_w-1:0]  src1, src2, dst, wb_reg, alu_dst, mem_dst;
    alu_op_e           alu_op, alu_op_out;
    logic [imme_w-1:0] imme, alu_imme, mem_imme;
    logic              wb_valid, oc_full, alu_valid, alu_imme_valid;
    logic              mem_valid, mem_read_out, mem_write_out, mem_imme_valid;
    logic [data_w-1:0] wb_data, alu_src1, alu_src2, mem_src1, mem_src2;

    logic [data_w-1:0] ref_regs [num_warps][regs_per_warp];
    op_rec_t           expected [$];
    op_rec_t           results [$];
    logic [31:0]       rng;

    rfoc_top rfoc_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #((num_instr * 40 + reset_cycles) * clk_period);
        fail_run("watchdog timeout, results did not arrive in time");
    end

    always @(negedge clk) begin : monitor
        op_rec_t rec;
        if (rst_n && alu_valid) begin
            rec = '{is_mem: 1'b0, warp: alu_warp, dst: alu_dst, src1: alu_src1,
                    src2: alu_src2, op: alu_op_out, mrd: 1'b0, mwr: 1'b0,
                    imme: alu_imme, imme_valid: alu_imme_valid};
            results.push_back(rec);
        end
        if (rst_n && mem_valid) begin
            rec = '{is_mem: 1'b1, warp: mem_warp, dst: mem_dst, src1: mem_src1,
                    src2: mem_src2, op: 4'd0, mrd: mem_read_out, mwr: mem_write_out,
                    imme: mem_imme, imme_valid: mem_imme_valid};
            results.push_back(rec);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want)
            fail_run($sformatf("CHECK FAILED at %0t: %s, got %0h expected %0h",
                               $time, what, got, want));
    endtask

    task automatic write_reg(input int w, input int r, input logic [data_w-1:0] d);
        wb_valid = 1'b1;
        wb_warp  = warp_w'(w);
        wb_reg   = reg_w'(r);
        wb_data  = d;
        ref_regs[w][r] = d;
        @(negedge clk);
        wb_valid = 1'b0;
    endtask

    task automatic issue_op(input int w, input int s1, input bit s1v, input int s2,
                            input bit s2v, input int d, input alu_op_e op, input bit mrd,
                            input bit mwr, input logic [imme_w-1:0] imm, input bit immv);
        op_rec_t rec;
        while (oc_full)
            @(negedge clk);
        issue_valid = 1'b1;
        warp_id     = warp_w'(w);
        src1        = reg_w'(s1);
        src1_valid  = s1v;
        src2        = reg_w'(s2);
        src2_valid  = s2v;
        dst         = reg_w'(d);
        alu_op      = op;
        mem_read    = mrd;
        mem_write   = mwr;
        imme        = imm;
        imme_valid  = immv;
        rec = '{is_mem: mrd || mwr, warp: warp_w'(w), dst: reg_w'(d),
                src1: s1v ? ref_regs[w][s1] : '0, src2: s2v ? ref_regs[w][s2] : '0,
                op: (mrd || mwr) ? 4'd0 : op, mrd: mrd, mwr: mwr,
                imme: imm, imme_valid: immv};
        expected.push_back(rec);
        @(negedge clk);
        issue_valid = 1'b0;
    endtask

    task automatic start_test();
        expected.delete();
        results.delete();
    endtask

    task automatic match_results(input string name);
        bit      used [64];
        int      hit;
        op_rec_t got, want;
        string   tag;
        check_eq(results.size(), expected.size(), {name, ": number of results"});
        foreach (results[i]) begin
            got = results[i];
            hit = -1;
            foreach (expected[j])
                if (expected[j].warp == got.warp && expected[j].dst == got.dst)
                    hit = j;
            if (hit < 0 || used[hit])
                fail_run($sformatf("%s: result for warp %0d dst %0d was never issued or came twice",
                                   name, got.warp, got.dst));
            used[hit] = 1'b1;
            want = expected[hit];
            tag  = $sformatf("%s warp %0d dst %0d", name, got.warp, got.dst);
            check_eq(got.is_mem, want.is_mem, {tag, " port"});
            check_eq(got.src1, want.src1, {tag, " src1"});
            check_eq(got.src2, want.src2, {tag, " src2"});
            check_eq(got.op, want.op, {tag, " opcode"});
            check_eq(got.mrd, want.mrd, {tag, " mem_read"});
            check_eq(got.mwr, want.mwr, {tag, " mem_write"});
            check_eq(got.imme, want.imme, {tag, " immediate"});
            check_eq(got.imme_valid, want.imme_valid, {tag, " imme_valid"});
        end
    endtask

    task automatic finish_test(input string name);
        while (results.size() < expected.size())
            @(posedge clk);
        repeat (10) @(posedge clk); // late duplicates would land here
        match_results(name);
        @(negedge clk);
    endtask

    task automatic test_idle_after_reset();
        repeat (10) begin
            @(negedge clk);
            check_eq(oc_full, 1'b0, "oc_full after reset");
            check_eq(alu_valid, 1'b0, "alu_valid after reset");
            check_eq(mem_valid, 1'b0, "mem_valid after reset");
        end
    endtask

    task automatic test_alu_two_sources();
        start_test();
        rng = xorshift(rng);
        write_reg(2, 1, rng);
        rng = xorshift(rng);
        write_reg(2, 6, rng);
        issue_op(2, 1, 1'b1, 6, 1'b1, 3, op_xor, 1'b0, 1'b0, 16'h1234, 1'b1);
        finish_test("alu two sources");
    endtask

    task automatic test_mem_read_immediate();
        start_test();
        rng = xorshift(rng);
        write_reg(5, 4, rng);
        rng = xorshift(rng);
        write_reg(5, 7, rng); // src2 holds data but is not requested
        issue_op(5, 4, 1'b1, 7, 1'b0, 2, op_add, 1'b1, 1'b0, 16'hbeef, 1'b1);
        finish_test("mem read immediate");
    endtask

    task automatic test_warp_mapping();
        start_test();
        write_reg(0, 5, 32'h0000_aaaa);
        write_reg(1, 5, 32'h1111_bbbb);
        write_reg(4, 5, 32'h4444_cccc); // same bank as warp 0, other row
        issue_op(0, 5, 1'b1, 5, 1'b1, 1, op_or, 1'b0, 1'b0, 16'h0, 1'b0);
        issue_op(1, 5, 1'b1, 5, 1'b1, 1, op_or, 1'b0, 1'b0, 16'h0, 1'b0);
        issue_op(4, 5, 1'b1, 5, 1'b1, 1, op_or, 1'b0, 1'b0, 16'h0, 1'b0);
        finish_test("warp mapping");
    endtask

    task automatic test_same_bank_with_writeback();
        start_test();
        for (int k = 0; k < 4; k++) begin
            rng = xorshift(rng);
            write_reg((k < 2) ? 3 : 7, (k % 2 == 1) ? 6 : 2, rng);
        end
        fork
            begin
                issue_op(3, 2, 1'b1, 6, 1'b1, 0, op_add, 1'b0, 1'b0, 16'h0003, 1'b0);
                issue_op(7, 2, 1'b1, 6, 1'b1, 0, op_sub, 1'b0, 1'b0, 16'h0007, 1'b1);
            end
            begin
                for (int k = 0; k < 6; k++) begin
                    rng = xorshift(rng);
                    write_reg(k / 2, (5 - k / 2) % 4 + 4 * (k % 2), rng); // bank 1 too
                end
            end
        join
        finish_test("same bank");
    endtask

    task automatic test_random_stream();
        logic [31:0] r;
        start_test();
        for (int w = 0; w < num_warps; w++) begin
            for (int g = 0; g < regs_per_warp; g++) begin
                rng = xorshift(rng);
                write_reg(w, g, rng);
            end
        end
        for (int i = 0; i < rand_instr; i++) begin
            rng = xorshift(rng);
            r   = rng;
            issue_op(i % num_warps, int'(r[6:4]), r[0] | r[1], int'(r[9:7]), r[2] | r[3],
                     i / num_warps, alu_op_e'(r[13:10]), r[14], r[15] & ~r[14],
                     r[31:16], r[5]);
        end
        finish_test("random stream");
    endtask

    initial begin
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        warp_id     = '0;
        src1        = '0;
        src1_valid  = 1'b0;
        src2        = '0;
        src2_valid  = 1'b0;
        dst         = '0;
        alu_op      = op_add;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        imme        = '0;
        imme_valid  = 1'b0;
        wb_valid    = 1'b0;
        wb_warp     = '0;
        wb_reg      = '0;
        wb_data     = '0;
        rng         = 32'hc1f7;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_idle_after_reset();
        test_alu_two_sources();
        test_mem_read_immediate();
        test_warp_mapping();
        test_same_bank_with_writeback();
        test_random_stream();
        $display("Test OK");
        $finish;
    end

endmodule
